//--- hdl/tg_defines.svh
// Fixed sizes of the traffic generator, included by the packages, the RTL and the testbench
`ifndef TG_DEFINES_SVH
`define TG_DEFINES_SVH

// Word address width of the memory port
`define TG_ADDR_W 16

// Data width of the memory port and of the CSR port
`define TG_DATA_W 32

// Entries in the expected-data FIFO, also the limit on outstanding reads
`define TG_EXP_DEPTH 16

// Idle cycles of a busy run before timeout is flagged
`define TG_TIMEOUT_CYCLES 64

`endif

//--- hdl/tg_cfg_pkg.sv
// Register-side types and the data pattern rule, imported by the CSR block and the generator
`default_nettype none
`include "tg_defines.svh"

package tg_cfg_pkg;

   // ------------------------------------------------------------
   // Register map
   // ------------------------------------------------------------
   typedef enum logic [3:0] {
      REG_BASE      = 4'd0,
      REG_COUNT     = 4'd1,
      REG_PATTERN   = 4'd2,
      REG_SEED      = 4'd3,
      REG_START     = 4'd4,
      REG_STATUS    = 4'd5,
      REG_CLOCKS_LO = 4'd6,
      REG_CLOCKS_HI = 4'd7
   } tg_reg_e;

   typedef enum logic [1:0] {
      PAT_CONST = 2'd0,
      PAT_ADDR  = 2'd1,
      PAT_WALK  = 2'd2
   } tg_pattern_e;

   // ------------------------------------------------------------
   // CSR port and run configuration
   // ------------------------------------------------------------
   typedef struct packed {
      logic                  wr;
      logic                  rd;
      tg_reg_e               addr;
      logic [`TG_DATA_W-1:0] wdata;
   } csr_req_t;

   typedef struct packed {
      logic                  rvalid;
      logic [`TG_DATA_W-1:0] rdata;
   } csr_rsp_t;

   typedef struct packed {
      logic [`TG_ADDR_W-1:0] base;
      logic [`TG_ADDR_W-1:0] count;
      tg_pattern_e           pattern;
      logic [`TG_DATA_W-1:0] seed;
   } tg_cfg_t;

   // Data word expected at address addr for a given pattern and seed
   function automatic logic [`TG_DATA_W-1:0] tg_pattern_data(
      input tg_pattern_e           pattern,
      input logic [`TG_DATA_W-1:0] seed,
      input logic [`TG_ADDR_W-1:0] addr
   );
      logic [`TG_DATA_W-1:0] walk;
      walk = '0;
      // Bit position is the address modulo the data width
      walk[addr[$clog2(`TG_DATA_W)-1:0]] = 1'b1;
      case (pattern)
         PAT_ADDR: return seed ^ `TG_DATA_W'(addr);
         PAT_WALK: return seed ^ walk;
         default:  return seed;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- hdl/tg_mem_pkg.sv
// Memory-side types for the generator, the checker and the memory port; import in the module body
`default_nettype none
`include "tg_defines.svh"

package tg_mem_pkg;

   // ------------------------------------------------------------
   // Memory port
   // ------------------------------------------------------------
   typedef struct packed {
      logic                  wr;
      logic                  rd;
      logic [`TG_ADDR_W-1:0] addr;
      logic [`TG_DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic                  rvalid;
      logic [`TG_DATA_W-1:0] rdata;
   } mem_rsp_t;

   // ------------------------------------------------------------
   // Generator to checker
   // ------------------------------------------------------------
   // One entry per read, last marks the final read of the pass
   typedef struct packed {
      logic [`TG_ADDR_W-1:0] addr;
      logic [`TG_DATA_W-1:0] data;
      logic                  last;
   } exp_item_t;

   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      WRITE = 2'd1,
      READ  = 2'd2,
      DRAIN = 2'd3
   } tg_gen_state_e;

   // Outcome of a run, held until the next start
   typedef struct packed {
      logic        busy;
      logic        pass;
      logic        fail;
      logic        timeout;
      logic [15:0] err_count;
   } tg_result_t;

endpackage

`default_nettype wire

//--- hdl/tg_csr_regs.sv
// CSR block of the traffic generator, decodes single-cycle accesses and issues the start pulse
`timescale 1ns/1ps
`default_nettype none
`include "tg_defines.svh"

module tg_csr_regs (
   input  wire                    clk,
   input  wire                    local_rst_n,
   input  wire tg_cfg_pkg::csr_req_t   csr_req,
   output tg_cfg_pkg::csr_rsp_t   csr_rsp,
   input  wire tg_mem_pkg::tg_result_t result,
   input  wire [63:0]             clock_count,
   output tg_cfg_pkg::tg_cfg_t    cfg,
   output logic                   start
);
   import tg_cfg_pkg::*;

   tg_cfg_t               cfg_q;
   logic                  rvalid_q;
   logic [`TG_DATA_W-1:0] rdata_q;
   logic [`TG_DATA_W-1:0] rdata_d;

   // ------------------------------------------------------------
   // Write side
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge local_rst_n) begin
      if (!local_rst_n) begin
         cfg_q <= '0;
         start <= 1'b0;
      end else begin
         // A start during a run is dropped
         start <= csr_req.wr && (csr_req.addr == REG_START) && !result.busy;
         if (csr_req.wr) begin
            case (csr_req.addr)
               REG_BASE:    cfg_q.base    <= csr_req.wdata[`TG_ADDR_W-1:0];
               REG_COUNT:   cfg_q.count   <= csr_req.wdata[`TG_ADDR_W-1:0];
               REG_PATTERN: cfg_q.pattern <= tg_pattern_e'(csr_req.wdata[1:0]);
               REG_SEED:    cfg_q.seed    <= csr_req.wdata;
               default:     ;
            endcase
         end
      end
   end

   assign cfg = cfg_q;

   // ------------------------------------------------------------
   // Read side
   // ------------------------------------------------------------
   always_comb begin
      rdata_d = '0;
      case (csr_req.addr)
         REG_BASE:      rdata_d = `TG_DATA_W'(cfg_q.base);
         REG_COUNT:     rdata_d = `TG_DATA_W'(cfg_q.count);
         REG_PATTERN:   rdata_d = `TG_DATA_W'(cfg_q.pattern);
         REG_SEED:      rdata_d = cfg_q.seed;
         // err_count on top, flags in the low nibble
         REG_STATUS:    rdata_d = `TG_DATA_W'({result.err_count, 12'd0, result.timeout,
                                              result.fail, result.pass, result.busy});
         REG_CLOCKS_LO: rdata_d = clock_count[31:0];
         REG_CLOCKS_HI: rdata_d = clock_count[63:32];
         default:       rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk or negedge local_rst_n) begin
      if (!local_rst_n) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= csr_req.rd;
      end
   end

   always_ff @(posedge clk) begin
      if (csr_req.rd) begin
         rdata_q <= rdata_d;
      end
   end

   // Response one cycle after rd, no back-pressure
   assign csr_rsp.rvalid = rvalid_q;
   assign csr_rsp.rdata  = rdata_q;

endmodule

`default_nettype wire

//--- hdl/tg_pattern_gen.sv
// Stage 1 of the generator, runs the write pass and the read pass and feeds the checker
`timescale 1ns/1ps
`default_nettype none
`include "tg_defines.svh"

module tg_pattern_gen (
   input  wire                      clk,
   input  wire                      local_rst_n,
   input  wire                      start,
   input  wire tg_cfg_pkg::tg_cfg_t cfg,
   input  wire                      mem_stall,
   input  wire                      exp_full,
   output tg_mem_pkg::mem_req_t     mem_req,
   output logic                     exp_push,
   output tg_mem_pkg::exp_item_t    exp_item
);
   import tg_cfg_pkg::*;
   import tg_mem_pkg::*;

   tg_gen_state_e         state;
   tg_cfg_t               run_cfg;
   logic [`TG_ADDR_W-1:0] addr_q;
   logic [`TG_ADDR_W-1:0] left_q;
   logic [`TG_DATA_W-1:0] pat_data;
   logic                  last_word;
   logic                  accept;

   assign last_word = (left_q == `TG_ADDR_W'(1));
   assign pat_data  = tg_pattern_data(run_cfg.pattern, run_cfg.seed, addr_q);

   // Strobes only in unstalled cycles, reads also wait for FIFO room
   assign mem_req.wr    = (state == WRITE) && !mem_stall && !start;
   assign mem_req.rd    = (state == READ) && !mem_stall && !exp_full && !start;
   assign mem_req.addr  = addr_q;
   assign mem_req.wdata = pat_data;
   assign accept        = mem_req.wr || mem_req.rd;

   assign exp_push      = mem_req.rd;
   assign exp_item.addr = addr_q;
   assign exp_item.data = pat_data;
   assign exp_item.last = last_word;

   // Settings of the current run, taken at start
   always_ff @(posedge clk) begin
      if (start) begin
         run_cfg <= cfg;
      end
   end

   // ------------------------------------------------------------
   // Sequencer
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge local_rst_n) begin
      if (!local_rst_n) begin
         state  <= IDLE;
         addr_q <= '0;
         left_q <= '0;
      end else if (start) begin
         // Restarts from any state, e.g. after a timeout left a pass open
         addr_q <= cfg.base;
         left_q <= cfg.count;
         state  <= (cfg.count == '0) ? IDLE : WRITE;
      end else begin
         case (state)
            WRITE, READ: begin
               if (accept && last_word) begin
                  addr_q <= run_cfg.base;
                  left_q <= run_cfg.count;
                  state  <= (state == WRITE) ? READ : DRAIN;
               end else if (accept) begin
                  // Wraps at the top of the address space
                  addr_q <= addr_q + 1'b1;
                  left_q <= left_q - 1'b1;
               end
            end
            // Turnaround cycle after the final read
            DRAIN:   state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/tg_read_check.sv
// Stage 2 of the generator, compares read data against the expected FIFO and owns the run result
`timescale 1ns/1ps
`default_nettype none
`include "tg_defines.svh"

module tg_read_check (
   input  wire                        clk,
   input  wire                        local_rst_n,
   input  wire                        start,
   input  wire tg_cfg_pkg::tg_cfg_t   cfg,
   input  wire                        exp_push,
   input  wire tg_mem_pkg::exp_item_t exp_item,
   input  wire tg_mem_pkg::mem_req_t  mem_req,
   input  wire tg_mem_pkg::mem_rsp_t  mem_rsp,
   output logic                       exp_full,
   output tg_mem_pkg::tg_result_t     result
);
   import tg_mem_pkg::*;

   localparam int PTR_W = $clog2(`TG_EXP_DEPTH);
   localparam int WD_W  = $clog2(`TG_TIMEOUT_CYCLES);
   localparam logic [PTR_W:0] FULL_LVL = `TG_EXP_DEPTH;

   exp_item_t        exp_mem [`TG_EXP_DEPTH];
   exp_item_t        head;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   fill;
   logic [WD_W-1:0]  idle_cnt;
   tg_result_t       res_q;
   logic             rsp_take;
   logic             mismatch;
   logic             idle;
   logic [15:0]      err_next;

   // ------------------------------------------------------------
   // Expected FIFO
   // ------------------------------------------------------------
   assign head     = exp_mem[rd_ptr];
   assign exp_full = (fill == FULL_LVL);

   always_ff @(posedge clk) begin
      if (exp_push) begin
         exp_mem[wr_ptr] <= exp_item;
      end
   end

   always_ff @(posedge clk or negedge local_rst_n) begin
      if (!local_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else if (start) begin
         // Drops items left over from a timed-out run
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (exp_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rsp_take) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         fill <= fill + (PTR_W+1)'(exp_push) - (PTR_W+1)'(rsp_take);
      end
   end

   // ------------------------------------------------------------
   // Compare and result
   // ------------------------------------------------------------
   // Responses count only during a run, so late data after timeout is ignored
   assign rsp_take = mem_rsp.rvalid && res_q.busy && (fill != '0);
   assign mismatch = rsp_take && (mem_rsp.rdata != head.data);
   assign err_next = (mismatch && (res_q.err_count != '1)) ? res_q.err_count + 16'd1
                                                           : res_q.err_count;
   assign idle     = !(mem_req.wr || mem_req.rd || mem_rsp.rvalid);

   always_ff @(posedge clk or negedge local_rst_n) begin
      if (!local_rst_n) begin
         res_q    <= '0;
         idle_cnt <= '0;
      end else if (start) begin
         res_q    <= '0;
         idle_cnt <= '0;
         // An empty run passes at once
         if (cfg.count == '0) begin
            res_q.pass <= 1'b1;
         end else begin
            res_q.busy <= 1'b1;
         end
      end else if (res_q.busy) begin
         res_q.err_count <= err_next;
         if (rsp_take && head.last) begin
            res_q.busy <= 1'b0;
            res_q.pass <= (err_next == '0);
            res_q.fail <= (err_next != '0);
         end else if (!idle) begin
            idle_cnt <= '0;
         end else if (idle_cnt == WD_W'(`TG_TIMEOUT_CYCLES - 1)) begin
            res_q.busy    <= 1'b0;
            res_q.timeout <= 1'b1;
         end else begin
            idle_cnt <= idle_cnt + 1'b1;
         end
      end
   end

   assign result = res_q;

endmodule

`default_nettype wire

//--- hdl/tg_run_timer.sv
// Cycle counter of the traffic generator, measures each run from start to its outcome
`timescale 1ns/1ps
`default_nettype none

module tg_run_timer (
   input  wire                         clk,
   input  wire                         local_rst_n,
   input  wire                         start,
   input  wire tg_mem_pkg::tg_result_t result,
   output logic [63:0]                 clock_count
);

   logic run_q;
   logic done;

   // Outcome flags are cleared by start, so a level marks the end
   assign done = result.pass || result.fail || result.timeout;

   always_ff @(posedge clk or negedge local_rst_n) begin
      if (!local_rst_n) begin
         run_q       <= 1'b0;
         clock_count <= '0;
      end else if (start) begin
         run_q       <= 1'b1;
         clock_count <= '0;
      end else begin
         if (run_q) begin
            clock_count <= clock_count + 64'd1;
         end
         // Final value stays until the next start
         if (done) begin
            run_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/tg_mem_top.sv
// Top of the memory traffic generator, wires the CSR block, both stages and the run timer
`timescale 1ns/1ps
`default_nettype none

module tg_mem_top (
   input  wire                         clk,
   input  wire                         local_rst_n,
   input  wire tg_cfg_pkg::csr_req_t   csr_req,
   output tg_cfg_pkg::csr_rsp_t        csr_rsp,
   output tg_mem_pkg::mem_req_t        mem_req,
   input  wire                         mem_stall,
   input  wire tg_mem_pkg::mem_rsp_t   mem_rsp,
   output logic                        tg_pass,
   output logic                        tg_fail,
   output logic                        tg_timeout,
   output logic [63:0]                 clock_count
);
   import tg_cfg_pkg::*;
   import tg_mem_pkg::*;

   tg_cfg_t    cfg;
   tg_result_t result;
   exp_item_t  exp_item;
   logic       start;
   logic       exp_push;
   logic       exp_full;

   // ------------------------------------------------------------
   // Register block
   // ------------------------------------------------------------
   tg_csr_regs i_csr_regs (
      .clk         (clk),
      .local_rst_n (local_rst_n),
      .csr_req     (csr_req),
      .csr_rsp     (csr_rsp),
      .result      (result),
      .clock_count (clock_count),
      .cfg         (cfg),
      .start       (start)
   );

   // ------------------------------------------------------------
   // Generator and checker stages
   // ------------------------------------------------------------
   tg_pattern_gen i_pattern_gen (
      .clk         (clk),
      .local_rst_n (local_rst_n),
      .start       (start),
      .cfg         (cfg),
      .mem_stall   (mem_stall),
      .exp_full    (exp_full),
      .mem_req     (mem_req),
      .exp_push    (exp_push),
      .exp_item    (exp_item)
   );

   tg_read_check i_read_check (
      .clk         (clk),
      .local_rst_n (local_rst_n),
      .start       (start),
      .cfg         (cfg),
      .exp_push    (exp_push),
      .exp_item    (exp_item),
      .mem_req     (mem_req),
      .mem_rsp     (mem_rsp),
      .exp_full    (exp_full),
      .result      (result)
   );

   tg_run_timer i_run_timer (
      .clk         (clk),
      .local_rst_n (local_rst_n),
      .start       (start),
      .result      (result),
      .clock_count (clock_count)
   );

   assign tg_pass    = result.pass;
   assign tg_fail    = result.fail;
   assign tg_timeout = result.timeout;

endmodule

`default_nettype wire

//--- sim/tg_mem_checker.sv
// Protocol assertions for the traffic generator top level, bound into every tg_mem_top
`timescale 1ns/1ps
`default_nettype none

module tg_mem_checker (
   input wire                       clk,
   input wire                       local_rst_n,
   input wire tg_cfg_pkg::csr_req_t csr_req,
   input wire tg_cfg_pkg::csr_rsp_t csr_rsp,
   input wire tg_mem_pkg::mem_req_t mem_req,
   input wire                       mem_stall,
   input wire                       tg_pass,
   input wire                       tg_fail,
   input wire                       tg_timeout
);

   // ------------------------------------------------------------
   // CSR port
   // ------------------------------------------------------------
   csr_excl_a: assert property (@(posedge clk) disable iff (!local_rst_n)
      !(csr_req.wr && csr_req.rd))
      else $error("CSR wr and rd high in the same cycle");

   // Exactly one cycle from rd to rvalid
   csr_rvalid_a: assert property (@(posedge clk) disable iff (!local_rst_n)
      csr_req.rd |=> csr_rsp.rvalid)
      else $error("CSR rvalid missing one cycle after rd");

   csr_no_rvalid_a: assert property (@(posedge clk) disable iff (!local_rst_n)
      !csr_req.rd |=> !csr_rsp.rvalid)
      else $error("CSR rvalid without rd in the previous cycle");

   // ------------------------------------------------------------
   // Memory port and outcome
   // ------------------------------------------------------------
   mem_stall_a: assert property (@(posedge clk) disable iff (!local_rst_n)
      mem_stall |-> !(mem_req.wr || mem_req.rd))
      else $error("Memory request issued while mem_stall is high");

   outcome_a: assert property (@(posedge clk) disable iff (!local_rst_n)
      $onehot0({tg_pass, tg_fail, tg_timeout}))
      else $error("More than one outcome flag is high");

endmodule

bind tg_mem_top tg_mem_checker i_checker (
   .clk         (clk),
   .local_rst_n (local_rst_n),
   .csr_req     (csr_req),
   .csr_rsp     (csr_rsp),
   .mem_req     (mem_req),
   .mem_stall   (mem_stall),
   .tg_pass     (tg_pass),
   .tg_fail     (tg_fail),
   .tg_timeout  (tg_timeout)
);

`default_nettype wire

//--- sim/tb_tg_mem.sv
// Testbench of the memory traffic generator, runs every test listed in the stimulus file
`timescale 1ns/1ps
`default_nettype none
`include "tg_defines.svh"

module tb_tg_mem;
   import tg_cfg_pkg::*;
   import tg_mem_pkg::*;

   localparam int DONE_LIMIT = 2000;

   logic                  clk = 1'b0;
   logic                  local_rst_n;
   csr_req_t              csr_req;
   csr_rsp_t              csr_rsp;
   mem_req_t              mem_req;
   logic                  mem_stall = 1'b0;
   mem_rsp_t              mem_rsp = '0;
   logic                  tg_pass;
   logic                  tg_fail;
   logic                  tg_timeout;
   logic [63:0]           clock_count;

   // Memory model state
   logic [`TG_DATA_W-1:0] mem [0:(1<<`TG_ADDR_W)-1];
   logic [`TG_DATA_W-1:0] rsp_data_q [$];
   int unsigned           rsp_due_q [$];
   int unsigned           cyc = 0;
   int unsigned           last_due = 0;
   int unsigned           due;
   int unsigned           wr_total = 0;
   int unsigned           rd_total = 0;
   logic                  corrupt_en = 1'b0;
   logic [`TG_ADDR_W-1:0] corrupt_addr = '0;
   logic                  hang_en = 1'b0;

   int                    errors = 0;
   int                    checks = 0;

   tg_mem_top i_tg_mem_top (
      .clk         (clk),
      .local_rst_n (local_rst_n),
      .csr_req     (csr_req),
      .csr_rsp     (csr_rsp),
      .mem_req     (mem_req),
      .mem_stall   (mem_stall),
      .mem_rsp     (mem_rsp),
      .tg_pass     (tg_pass),
      .tg_fail     (tg_fail),
      .tg_timeout  (tg_timeout),
      .clock_count (clock_count)
   );

   // 100 ns period
   always #50 clk = ~clk;

   // ------------------------------------------------------------
   // Memory model
   // ------------------------------------------------------------
   always @(posedge clk) begin
      if (!local_rst_n) begin
         mem_stall <= 1'b0;
         mem_rsp   <= '0;
      end else begin
         cyc = cyc + 1;
         mem_stall <= (($urandom % 4) == 0);
         if (mem_req.wr) begin
            wr_total = wr_total + 1;
            // Optional bit 0 flip on one address
            mem[mem_req.addr] <= mem_req.wdata
                                 ^ 32'(corrupt_en && (mem_req.addr == corrupt_addr));
         end
         if (mem_req.rd) begin
            rd_total = rd_total + 1;
            if (!hang_en) begin
               due = cyc + ($urandom % 3);
               // Keep responses in order, one per cycle
               if (due <= last_due) begin
                  due = last_due + 1;
               end
               last_due = due;
               rsp_data_q.push_back(mem[mem_req.addr]);
               rsp_due_q.push_back(due);
            end
         end
         if ((rsp_due_q.size() > 0) && (rsp_due_q[0] <= cyc)) begin
            mem_rsp <= '{rvalid: 1'b1, rdata: rsp_data_q.pop_front()};
            void'(rsp_due_q.pop_front());
         end else begin
            mem_rsp <= '0;
         end
      end
   end

   // ------------------------------------------------------------
   // CSR access and compare tasks
   // ------------------------------------------------------------
   task automatic write_reg(input tg_reg_e addr, input logic [31:0] data);
      @(posedge clk);
      csr_req <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
      @(posedge clk);
      csr_req <= '0;
   endtask

   task automatic read_reg(input tg_reg_e addr, output csr_rsp_t rsp);
      @(posedge clk);
      csr_req <= '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
      @(posedge clk);
      csr_req <= '0;
      // Registered response, visible after the edge that took rd
      @(negedge clk);
      rsp = csr_rsp;
   endtask

   task automatic report_fail(input string msg);
      errors++;
      $display("FAIL at %0t ns: %s", $time, msg);
   endtask

   task automatic check_reg(input string name, input csr_rsp_t rsp, input logic [31:0] exp);
      checks++;
      if (!rsp.rvalid) begin
         report_fail($sformatf("%s read gave no rvalid one cycle after rd", name));
      end else if (rsp.rdata !== exp) begin
         report_fail($sformatf("%s read %h, expected %h", name, rsp.rdata, exp));
      end
   endtask

   task automatic check_result(input tg_result_t act, input tg_result_t exp);
      checks++;
      if (act !== exp) begin
         report_fail($sformatf("busy/pass/fail/timeout %b%b%b%b err %0d, expected %b%b%b%b err %0d",
                               act.busy, act.pass, act.fail, act.timeout, act.err_count,
                               exp.busy, exp.pass, exp.fail, exp.timeout, exp.err_count));
      end
   endtask

   task automatic check_mem_word(input logic [`TG_ADDR_W-1:0] addr, input logic [31:0] exp);
      checks++;
      if (mem[addr] !== exp) begin
         report_fail($sformatf("memory word %h holds %h, expected %h", addr, mem[addr], exp));
      end
   endtask

   // Data pattern rule for word address addr
   function automatic logic [31:0] expected_word(input logic [1:0] pat, input logic [31:0] seed,
                                                 input logic [15:0] addr);
      logic [31:0] one_hot;
      one_hot = 32'd1 << addr[4:0];
      case (pat)
         2'd1:    return seed ^ {16'd0, addr};
         2'd2:    return seed ^ one_hot;
         default: return seed;
      endcase
   endfunction

   task automatic wait_done(input int id);
      int n;
      n = 0;
      while (!(tg_pass || tg_fail || tg_timeout) && (n < DONE_LIMIT)) begin
         @(negedge clk);
         n++;
      end
      if (!(tg_pass || tg_fail || tg_timeout)) begin
         errors++;
         $display("Test %0d did not finish within %0d cycles", id, DONE_LIMIT);
      end
   endtask

   // ------------------------------------------------------------
   // One test from the stimulus file
   // ------------------------------------------------------------
   task automatic run_test(input int id, input logic [15:0] base, input logic [15:0] count,
                           input logic [1:0] pat, input logic [31:0] seed, input logic corrupt,
                           input logic [15:0] caddr, input logic hang,
                           input logic [1:0] outcome, input logic [15:0] exp_err);
      csr_rsp_t    rsp;
      tg_result_t  act;
      tg_result_t  exp;
      logic [63:0] cc;
      logic [15:0] a;
      logic [31:0] word;
      int unsigned wr_start;
      int unsigned rd_start;
      int          errors_start;
      int          i;

      errors_start = errors;
      write_reg(REG_BASE, 32'(base));
      write_reg(REG_COUNT, 32'(count));
      write_reg(REG_PATTERN, 32'(pat));
      write_reg(REG_SEED, seed);
      read_reg(REG_BASE, rsp);
      check_reg("BASE", rsp, 32'(base));
      read_reg(REG_COUNT, rsp);
      check_reg("COUNT", rsp, 32'(count));
      read_reg(REG_PATTERN, rsp);
      check_reg("PATTERN", rsp, 32'(pat));
      read_reg(REG_SEED, rsp);
      check_reg("SEED", rsp, seed);

      corrupt_en   = corrupt;
      corrupt_addr = caddr;
      hang_en      = hang;
      wr_start     = wr_total;
      rd_start     = rd_total;
      write_reg(REG_START, 32'd0);
      // Flags of the previous run clear with the start pulse
      @(posedge clk);
      @(negedge clk);

      if (hang) begin
         repeat (4) @(negedge clk);
         cc = clock_count;
         write_reg(REG_START, 32'd0);
         @(posedge clk);
         @(negedge clk);
         checks++;
         if (clock_count <= cc) begin
            report_fail("START during a busy run restarted the run");
         end
      end

      wait_done(id);
      read_reg(REG_STATUS, rsp);
      act.busy      = rsp.rdata[0];
      act.pass      = rsp.rdata[1];
      act.fail      = rsp.rdata[2];
      act.timeout   = rsp.rdata[3];
      act.err_count = rsp.rdata[31:16];
      exp.busy      = 1'b0;
      exp.pass      = (outcome == 2'd0);
      exp.fail      = (outcome == 2'd1);
      exp.timeout   = (outcome == 2'd2);
      exp.err_count = exp_err;
      check_result(act, exp);

      // Outcome flags on the top-level ports
      act.pass    = tg_pass;
      act.fail    = tg_fail;
      act.timeout = tg_timeout;
      check_result(act, exp);

      // Run length and frozen timer
      cc = clock_count;
      checks++;
      if (cc < (64'(count) << 1)) begin
         report_fail($sformatf("clock_count %0d below twice the count %0d", cc, count));
      end
      repeat (5) @(negedge clk);
      checks++;
      if (clock_count !== cc) begin
         report_fail("clock_count kept changing after completion");
      end
      read_reg(REG_CLOCKS_LO, rsp);
      check_reg("CLOCKS_LO", rsp, cc[31:0]);
      read_reg(REG_CLOCKS_HI, rsp);
      check_reg("CLOCKS_HI", rsp, cc[63:32]);

      for (i = 0; i < int'(count); i++) begin
         a    = base + 16'(i);
         word = expected_word(pat, seed, a);
         if (corrupt && (a == caddr)) begin
            word[0] = ~word[0];
         end
         check_mem_word(a, word);
      end

      checks++;
      if (((wr_total - wr_start) != 32'(count)) || ((rd_total - rd_start) != 32'(count))) begin
         report_fail($sformatf("%0d writes and %0d reads, expected %0d each",
                               wr_total - wr_start, rd_total - rd_start, count));
      end

      if (errors == errors_start) begin
         $display("Test %0d: ok", id);
      end else begin
         $display("Test %0d: %0d errors", id, errors - errors_start);
      end
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      int          fd;
      int          n;
      int          id;
      string       line;
      logic [15:0] base;
      logic [15:0] count;
      logic [1:0]  pat;
      logic [31:0] seed;
      logic        corrupt;
      logic [15:0] caddr;
      logic        hang;
      logic [1:0]  outcome;
      logic [15:0] exp_err;

      local_rst_n = 1'b0;
      csr_req     = '0;
      id          = 0;
      void'($urandom(96835));
      fd          = $fopen("sim/tg_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open the stimulus file sim/tg_input.txt");
      end else begin
         repeat (5) @(posedge clk);
         local_rst_n <= 1'b1;
         while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            // Lines starting with # are column notes
            if ((n > 0) && (line.getc(0) != "#")) begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", base, count, pat, seed,
                           corrupt, caddr, hang, outcome, exp_err);
               if (n == 9) begin
                  id++;
                  run_test(id, base, count, pat, seed, corrupt, caddr, hang, outcome, exp_err);
               end
            end
         end
         $fclose(fd);
      end
      $display("Tests %0d, checks %0d, errors %0d", id, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/tg_input.txt
# base count pattern seed corrupt corrupt_addr hang outcome err_count, all hex
# pattern 0 const 1 addr 2 walk, outcome 0 pass 1 fail 2 timeout
0100 0010 0 a5a5a5a5 0 0000 0 0 0000
0200 0024 1 12345678 0 0000 0 0 0000
0300 0028 2 00000000 0 0000 0 0 0000
fff8 0010 1 deadbeef 0 0000 0 0 0000
0400 0010 2 0f0f0f0f 1 0405 0 1 0001
0500 0010 0 5a5a5a5a 1 0520 0 0 0000
0600 0008 1 cafef00d 0 0000 1 2 0000
0700 0000 0 11111111 0 0000 0 0 0000
0800 0030 2 ffffffff 0 0000 0 0 0000
0900 0001 0 00c0ffee 0 0000 0 0 0000

//--- src.f
+incdir+hdl
hdl/tg_cfg_pkg.sv
hdl/tg_mem_pkg.sv
hdl/tg_csr_regs.sv
hdl/tg_pattern_gen.sv
hdl/tg_read_check.sv
hdl/tg_run_timer.sv
hdl/tg_mem_top.sv
sim/tg_mem_checker.sv
sim/tb_tg_mem.sv

//--- Makefile
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tg_mem -f src.f
	./obj_dir/Vtb_tg_mem > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module tb_tg_mem -f src.f

clean:
	rm -rf obj_dir $(LOG)
